// File: Makefile
SIM  := obj_dir/Vtb_rvv_core
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rvv_core \
	  -f compile.f -o Vtb_rvv_core

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

// File: backend/rvv_cmd_queue.sv
// In-order vector command queue
`timescale 1ns/1ns
`default_nettype none

module rvv_cmd_queue (
  input  logic                              clk,
  input  logic                              arst_n_i,
  input  logic                              push_valid_i,
  input  rvv_isa_pkg::rvv_cmd_t             push_cmd_i,
  input  logic                              stall_i,
  output logic                              issue_valid_o,
  output rvv_isa_pkg::rvv_cmd_t             issue_cmd_o,
  output logic [rvv_cfg_pkg::CQ_CNT_W-1:0]  free_o,
  output logic                              empty_o
);
  import rvv_cfg_pkg::*;
  import rvv_isa_pkg::*;

  rvv_cmd_t             mem_q [CQ_DEPTH];
  logic [CQ_PTR_W-1:0]  wr_ptr_q;
  logic [CQ_PTR_W-1:0]  rd_ptr_q;
  logic [CQ_CNT_W-1:0]  count_q;
  logic                 pop;

  function automatic logic [CQ_PTR_W-1:0] next_ptr(input logic [CQ_PTR_W-1:0] ptr);
    if (ptr == CQ_PTR_W'(CQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign pop = !empty_o && !stall_i;

  // Head is broadcast to every lane
  assign issue_valid_o = pop;
  assign issue_cmd_o = mem_q[rd_ptr_q];

  // A push in this cycle already owns one slot
  assign free_o = CQ_CNT_W'(CQ_DEPTH) - count_q - CQ_CNT_W'(push_valid_i);

  always_ff @(posedge clk) begin
    if (push_valid_i) begin
      mem_q[wr_ptr_q] <= push_cmd_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_valid_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_valid_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: backend/rvv_lane.sv
// Vector lane with register slice
`timescale 1ns/1ns
`default_nettype none

module rvv_lane #(
  parameter int LANE_IDX = 0
) (
  input  logic                              clk,
  input  logic                              arst_n_i,
  input  logic                              issue_valid_i,
  input  rvv_isa_pkg::rvv_cmd_t             issue_cmd_i,
  output rvv_isa_pkg::rvv_lane_res_t        res_o
);
  import rvv_cfg_pkg::*;
  import rvv_isa_pkg::*;

  localparam logic [VL_W-1:0] LANE_POS = VL_W'(LANE_IDX);

  logic [ELEN-1:0]    vreg_q [NUM_VREGS];
  logic [ELEN-1:0]    vs1;
  logic [ELEN-1:0]    vs2;
  logic [ELEN-1:0]    alu;
  logic               active;
  logic               is_red;
  logic               res_valid_q;
  logic               res_red_q;
  logic [XREG_AW-1:0] res_rd_q;
  logic [ELEN-1:0]    res_elem_q;

  assign vs1 = vreg_q[issue_cmd_i.vs1];
  assign vs2 = vreg_q[issue_cmd_i.vs2];
  // Tail elements stay untouched
  assign active = LANE_POS < issue_cmd_i.vl;
  assign is_red = (issue_cmd_i.op == OP_VREDSUM);

  always_comb begin
    case (issue_cmd_i.op)
      OP_VADD_VV: alu = vs2 + vs1;
      OP_VSUB_VV: alu = vs2 - vs1;
      OP_VAND_VV: alu = vs2 & vs1;
      OP_VXOR_VV: alu = vs2 ^ vs1;
      OP_VADD_VX: alu = vs2 + issue_cmd_i.scalar;
      OP_VMV_VX:  alu = issue_cmd_i.scalar;
      OP_VID:     alu = ELEN'(LANE_IDX);
      // Reduction passes its source element on
      OP_VREDSUM: alu = vs2;
      default:    alu = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_VREGS; i++) begin
        vreg_q[i] <= '0;
      end
    end else if (issue_valid_i && active && !is_red) begin
      vreg_q[issue_cmd_i.vd] <= alu;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_i) begin
      res_red_q <= is_red;
      res_rd_q <= issue_cmd_i.rd;
      res_elem_q <= active ? alu : '0;
    end
  end

  assign res_o = '{valid: res_valid_q, reduce: res_red_q, rd: res_rd_q, elem: res_elem_q};

endmodule

`default_nettype wire

// File: backend/rvv_retire.sv
// Reduction retire and scalar writeback
`timescale 1ns/1ns
`default_nettype none

module rvv_retire (
  input  logic                                                    clk,
  input  logic                                                    arst_n_i,
  input  rvv_isa_pkg::rvv_lane_res_t [rvv_cfg_pkg::NUM_LANES-1:0] lane_res_i,
  input  logic [rvv_cfg_pkg::ELEN-1:0]                            scalar_i,
  input  logic                                                    async_rd_ready_i,
  output logic                                                    async_rd_valid_o,
  output logic [rvv_cfg_pkg::XREG_AW-1:0]                         async_rd_addr_o,
  output logic [rvv_cfg_pkg::ELEN-1:0]                            async_rd_data_o,
  output logic                                                    stall_o,
  output logic                                                    busy_o
);
  import rvv_cfg_pkg::*;

  logic            red_arrive;
  logic [ELEN-1:0] sum;

  // All lanes move in lockstep, lane 0 speaks for them
  assign red_arrive = lane_res_i[0].valid && lane_res_i[0].reduce;

  always_comb begin
    sum = scalar_i;
    for (int i = 0; i < NUM_LANES; i++) begin
      sum = sum + lane_res_i[i].elem;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      async_rd_valid_o <= 1'b0;
    end else if (red_arrive) begin
      async_rd_valid_o <= 1'b1;
    end else if (async_rd_ready_i) begin
      async_rd_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (red_arrive) begin
      async_rd_addr_o <= lane_res_i[0].rd;
      async_rd_data_o <= sum;
    end
  end

  // Hold issue while a result is in flight or waiting
  assign stall_o = async_rd_valid_o || red_arrive;
  assign busy_o = async_rd_valid_o;

endmodule

`default_nettype wire

// File: bench/rvv_core_properties.sv
// Core interface assertions
`timescale 1ns/1ns
`default_nettype none

module rvv_core_properties (
  input logic                            clk,
  input logic                            arst_n_i,
  input logic                            inst_valid_i,
  input rvv_isa_pkg::rvv_inst_u          inst_data_i,
  input logic                            inst_ready_i,
  input logic [rvv_cfg_pkg::CAP_W-1:0]   queue_capacity_i,
  input logic                            reg_write_valid_i,
  input logic                            async_rd_valid_i,
  input logic [rvv_cfg_pkg::XREG_AW-1:0] async_rd_addr_i,
  input logic [rvv_cfg_pkg::ELEN-1:0]    async_rd_data_i,
  input logic                            async_rd_ready_i
);
  import rvv_isa_pkg::*;

  logic cfg_acc;

  assign cfg_acc = inst_valid_i && inst_ready_i && (inst_data_i.cfg.kind == KIND_CFG);

  ready_needs_capacity: assert property (@(posedge clk) disable iff (!arst_n_i)
    (queue_capacity_i == '0) |-> !inst_ready_i)
    else $error("inst_ready_o high while queue capacity is zero");

  // Writeback holds still under back-pressure
  rd_stable_while_stalled: assert property (@(posedge clk) disable iff (!arst_n_i)
    async_rd_valid_i && !async_rd_ready_i |=>
      async_rd_valid_i && $stable(async_rd_addr_i) && $stable(async_rd_data_i))
    else $error("async_rd outputs changed while waiting for ready");

  reg_write_back_to_back: assert property (@(posedge clk) disable iff (!arst_n_i)
    reg_write_valid_i && $past(reg_write_valid_i) |-> $past(cfg_acc) && $past(cfg_acc, 2))
    else $error("reg_write_valid_o high twice without two configurations");

  valid_low_in_reset: assert property (@(posedge clk)
    !arst_n_i |-> !reg_write_valid_i && !async_rd_valid_i)
    else $error("valid output high during reset");

endmodule

`default_nettype wire

// File: bench/tb_rvv_core.sv
// Vector core testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rvv_core;
  import rvv_cfg_pkg::*;
  import rvv_isa_pkg::*;

  localparam int NUM_INSTS      = 400;
  localparam int TIMEOUT_CYCLES = NUM_INSTS * 12 + 200;

  typedef struct packed {
    logic [XREG_AW-1:0] rd;
    logic [ELEN-1:0]    data;
  } wb_t;

  logic               clk;
  logic               arst_n_i;
  logic               inst_valid_i;
  rvv_inst_u          inst_data_i;
  logic [ELEN-1:0]    scalar_i;
  logic               inst_ready_o;
  logic               reg_write_valid_o;
  logic [XREG_AW-1:0] reg_write_addr_o;
  logic [ELEN-1:0]    reg_write_data_o;
  logic               async_rd_valid_o;
  logic [XREG_AW-1:0] async_rd_addr_o;
  logic [ELEN-1:0]    async_rd_data_o;
  logic               async_rd_ready_i;
  logic [VL_W-1:0]    config_vl_o;
  logic [CAP_W-1:0]   queue_capacity_o;
  logic               rvv_idle_o;

  logic [ELEN-1:0] model_vreg [NUM_VREGS][NUM_LANES];
  int              model_vl;
  wb_t             cfg_exp_q [$];
  wb_t             red_exp_q [$];
  int              errors;
  int              checks;
  int              cycles;
  int              full_cycles;
  bit              cfg_sent;
  // Last result seen while ready was low
  bit              rd_held;
  wb_t             rd_last;

  rvv_core i_rvv_core (.*);

  bind rvv_core rvv_core_properties i_properties (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .inst_valid_i      (inst_valid_i),
    .inst_data_i       (inst_data_i),
    .inst_ready_i      (inst_ready_o),
    .queue_capacity_i  (queue_capacity_o),
    .reg_write_valid_i (reg_write_valid_o),
    .async_rd_valid_i  (async_rd_valid_o),
    .async_rd_addr_i   (async_rd_addr_o),
    .async_rd_data_i   (async_rd_data_o),
    .async_rd_ready_i  (async_rd_ready_i)
  );

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the core did not drain within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [ELEN-1:0] exp,
                             input logic [ELEN-1:0] act);
    checks++;
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic random_inst(input int idx, output rvv_inst_u inst,
                             output logic [ELEN-1:0] scalar);
    int pick;
    pick = int'($urandom % 12);
    inst = '0;
    scalar = $urandom;
    if (idx < NUM_VREGS) begin
      // Fill every register once before the random mix
      inst.arith.kind = KIND_ARITH;
      inst.arith.funct = ($urandom % 2 == 0) ? OP_VID : OP_VMV_VX;
      inst.arith.vd = VREG_AW'(idx);
    end else if (pick == 0) begin
      inst.cfg.kind = KIND_CFG;
      inst.cfg.rd = XREG_AW'($urandom);
      inst.cfg.avl = AVL_W'($urandom % 8);
    end else begin
      inst.arith.kind = KIND_ARITH;
      if (pick <= 2) begin
        inst.arith.funct = OP_VREDSUM;
      end else begin
        inst.arith.funct = rvv_op_e'(OP_W'($urandom % 7));
      end
      inst.arith.vd = VREG_AW'($urandom);
      inst.arith.vs1 = VREG_AW'($urandom);
      inst.arith.vs2 = VREG_AW'($urandom);
      inst.arith.rd = XREG_AW'($urandom);
    end
  endtask

  task automatic model_apply(input rvv_inst_u inst, input logic [ELEN-1:0] scalar);
    wb_t             wb;
    logic [ELEN-1:0] sum;
    logic [ELEN-1:0] a;
    logic [ELEN-1:0] b;
    if (inst.cfg.kind == KIND_CFG) begin
      model_vl = int'(inst.cfg.avl);
      if (model_vl > NUM_LANES) begin
        model_vl = NUM_LANES;
      end
      wb.rd = inst.cfg.rd;
      wb.data = ELEN'(model_vl);
      cfg_exp_q.push_back(wb);
    end else begin
      sum = scalar;
      for (int i = 0; i < model_vl; i++) begin
        a = model_vreg[inst.arith.vs2][i];
        b = model_vreg[inst.arith.vs1][i];
        case (inst.arith.funct)
          OP_VADD_VV: model_vreg[inst.arith.vd][i] = a + b;
          OP_VSUB_VV: model_vreg[inst.arith.vd][i] = a - b;
          OP_VAND_VV: model_vreg[inst.arith.vd][i] = a & b;
          OP_VXOR_VV: model_vreg[inst.arith.vd][i] = a ^ b;
          OP_VADD_VX: model_vreg[inst.arith.vd][i] = a + scalar;
          OP_VMV_VX:  model_vreg[inst.arith.vd][i] = scalar;
          OP_VID:     model_vreg[inst.arith.vd][i] = ELEN'(i);
          default:    sum = sum + a;
        endcase
      end
      if (inst.arith.funct == OP_VREDSUM) begin
        wb.rd = inst.arith.rd;
        wb.data = sum;
        red_exp_q.push_back(wb);
      end
    end
  endtask

  task automatic sample_outputs();
    wb_t exp;
    // An accepted reduction keeps the core busy until its result shows
    if (red_exp_q.size() > 0) begin
      check_value("idle_while_pending", 0, ELEN'(rvv_idle_o));
    end
    check_value("reg_write_valid", ELEN'(cfg_sent), ELEN'(reg_write_valid_o));
    if (cfg_sent) begin
      exp = cfg_exp_q.pop_front();
      check_value("reg_write_addr", ELEN'(exp.rd), ELEN'(reg_write_addr_o));
      check_value("reg_write_data", exp.data, reg_write_data_o);
      check_value("config_vl", exp.data, ELEN'(config_vl_o));
    end
    if (rd_held) begin
      check_value("async_rd_valid_held", 1, ELEN'(async_rd_valid_o));
      check_value("async_rd_addr_held", ELEN'(rd_last.rd), ELEN'(async_rd_addr_o));
      check_value("async_rd_data_held", rd_last.data, async_rd_data_o);
    end else if (async_rd_valid_o) begin
      if (red_exp_q.size() == 0) begin
        $display("Reduction result for rd %0d appeared with none outstanding",
                 async_rd_addr_o);
        errors++;
      end else begin
        exp = red_exp_q.pop_front();
        check_value("async_rd_addr", ELEN'(exp.rd), ELEN'(async_rd_addr_o));
        check_value("async_rd_data", exp.data, async_rd_data_o);
      end
    end
  endtask

  // Sample at edge plus 2 ns, then drive
  task automatic step(input bit offer, input rvv_inst_u inst,
                      input logic [ELEN-1:0] scalar, output bit accepted);
    @(posedge clk);
    #2;
    sample_outputs();
    if (!inst_ready_o) begin
      full_cycles++;
    end
    inst_data_i = inst;
    scalar_i = scalar;
    inst_valid_i = offer && ($urandom % 4 != 0);
    async_rd_ready_i = ($urandom % 10) >= 4;
    accepted = inst_valid_i && inst_ready_o;
    cfg_sent = accepted && (inst.cfg.kind == KIND_CFG);
    rd_held = async_rd_valid_o && !async_rd_ready_i;
    rd_last.rd = async_rd_addr_o;
    rd_last.data = async_rd_data_o;
  endtask

  initial begin
    rvv_inst_u       inst;
    logic [ELEN-1:0] scalar;
    bit              accepted;
    errors = 0;
    checks = 0;
    cycles = 0;
    full_cycles = 0;
    cfg_sent = 1'b0;
    rd_held = 1'b0;
    rd_last = '0;
    model_vl = NUM_LANES;
    for (int r = 0; r < NUM_VREGS; r++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        model_vreg[r][l] = '0;
      end
    end
    arst_n_i = 1'b0;
    inst_valid_i = 1'b0;
    inst_data_i = '0;
    scalar_i = '0;
    async_rd_ready_i = 1'b0;
    void'($urandom(10068));
    repeat (16) @(posedge clk);
    #2;
    arst_n_i = 1'b1;
    check_value("ready_after_reset", 1, ELEN'(inst_ready_o));
    check_value("vl_after_reset", NUM_LANES, ELEN'(config_vl_o));

    for (int n = 0; n < NUM_INSTS; n++) begin
      random_inst(n, inst, scalar);
      accepted = 1'b0;
      while (!accepted) begin
        step(1'b1, inst, scalar, accepted);
      end
      model_apply(inst, scalar);
    end

    // Wait for the idle flag with results still draining
    inst = '0;
    while (red_exp_q.size() > 0 || cfg_sent || !rvv_idle_o) begin
      step(1'b0, inst, '0, accepted);
    end
    repeat (4) step(1'b0, inst, '0, accepted);
    check_value("capacity_at_end", CAP_MAX, ELEN'(queue_capacity_o));
    if (full_cycles == 0) begin
      $display("inst_ready_o never dropped under writeback back-pressure");
      errors++;
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: common/rvv_cfg_pkg.sv
// Vector core sizing
`default_nettype none

package rvv_cfg_pkg;

  // Lanes, which is also the maximum vector length
  localparam int NUM_LANES = 4;
  localparam int NUM_VREGS = 8;
  localparam int ELEN      = 32;
  localparam int CQ_DEPTH  = 8;
  // Reported capacity never exceeds this
  localparam int CAP_MAX   = 2;

  localparam int VL_W      = $clog2(NUM_LANES + 1);
  localparam int VREG_AW   = $clog2(NUM_VREGS);
  localparam int XREG_AW   = 5;
  localparam int CQ_PTR_W  = $clog2(CQ_DEPTH);
  localparam int CQ_CNT_W  = $clog2(CQ_DEPTH + 1);
  localparam int CAP_W     = $clog2(CAP_MAX + 1);

endpackage

`default_nettype wire

// File: common/rvv_isa_pkg.sv
// Vector instruction and command formats
`default_nettype none

package rvv_isa_pkg;

  localparam int INST_W = 32;
  localparam int AVL_W  = 8;
  localparam int OP_W   = 4;

  // Kind bit at the top of every instruction word
  localparam logic KIND_CFG   = 1'b1;
  localparam logic KIND_ARITH = 1'b0;

  localparam int CFG_PAD_W   = INST_W - 1 - rvv_cfg_pkg::XREG_AW - AVL_W;
  localparam int ARITH_PAD_W = INST_W - 1 - OP_W - 3 * rvv_cfg_pkg::VREG_AW
                               - rvv_cfg_pkg::XREG_AW;

  typedef enum logic [OP_W-1:0] {
    OP_VADD_VV  = 4'd0,
    OP_VSUB_VV  = 4'd1,
    OP_VAND_VV  = 4'd2,
    OP_VXOR_VV  = 4'd3,
    OP_VADD_VX  = 4'd4,
    OP_VMV_VX   = 4'd5,
    OP_VID      = 4'd6,
    OP_VREDSUM  = 4'd7
  } rvv_op_e;

  // Set-vector-length view
  typedef struct packed {
    logic                              kind;
    logic [rvv_cfg_pkg::XREG_AW-1:0]   rd;
    logic [AVL_W-1:0]                  avl;
    logic [CFG_PAD_W-1:0]              pad;
  } rvv_cfg_inst_t;

  // Arithmetic view, rd only matters for reductions
  typedef struct packed {
    logic                              kind;
    rvv_op_e                           funct;
    logic [rvv_cfg_pkg::VREG_AW-1:0]   vd;
    logic [rvv_cfg_pkg::VREG_AW-1:0]   vs1;
    logic [rvv_cfg_pkg::VREG_AW-1:0]   vs2;
    logic [rvv_cfg_pkg::XREG_AW-1:0]   rd;
    logic [ARITH_PAD_W-1:0]            pad;
  } rvv_arith_inst_t;

  typedef union packed {
    rvv_cfg_inst_t   cfg;
    rvv_arith_inst_t arith;
  } rvv_inst_u;

  typedef struct packed {
    rvv_op_e                           op;
    logic [rvv_cfg_pkg::VREG_AW-1:0]   vd;
    logic [rvv_cfg_pkg::VREG_AW-1:0]   vs1;
    logic [rvv_cfg_pkg::VREG_AW-1:0]   vs2;
    logic [rvv_cfg_pkg::XREG_AW-1:0]   rd;
    logic [rvv_cfg_pkg::ELEN-1:0]      scalar;
    logic [rvv_cfg_pkg::VL_W-1:0]      vl;
  } rvv_cmd_t;

  typedef struct packed {
    logic                              valid;
    logic                              reduce;
    logic [rvv_cfg_pkg::XREG_AW-1:0]   rd;
    logic [rvv_cfg_pkg::ELEN-1:0]      elem;
  } rvv_lane_res_t;

endpackage

`default_nettype wire

// File: compile.f
common/rvv_cfg_pkg.sv
common/rvv_isa_pkg.sv
frontend/rvv_frontend.sv
backend/rvv_cmd_queue.sv
backend/rvv_lane.sv
backend/rvv_retire.sv
rtl/rvv_core.sv
bench/rvv_core_properties.sv
bench/tb_rvv_core.sv

// File: frontend/rvv_frontend.sv
// Vector instruction front end
`timescale 1ns/1ns
`default_nettype none

module rvv_frontend (
  input  logic                              clk,
  input  logic                              arst_n_i,
  input  logic                              inst_valid_i,
  input  rvv_isa_pkg::rvv_inst_u            inst_data_i,
  input  logic [rvv_cfg_pkg::ELEN-1:0]      scalar_i,
  input  logic                              inst_ready_i,
  output logic                              reg_write_valid_o,
  output logic [rvv_cfg_pkg::XREG_AW-1:0]   reg_write_addr_o,
  output logic [rvv_cfg_pkg::ELEN-1:0]      reg_write_data_o,
  output logic [rvv_cfg_pkg::VL_W-1:0]      config_vl_o,
  output logic                              cmd_valid_o,
  output rvv_isa_pkg::rvv_cmd_t             cmd_o,
  output logic                              busy_o
);
  import rvv_cfg_pkg::*;
  import rvv_isa_pkg::*;

  logic            cfg_acc;
  logic            arith_acc;
  logic [VL_W-1:0] new_vl;
  logic [VL_W-1:0] vl_q;

  // Decode by kind bit, only on an accepted instruction
  always_comb begin
    cfg_acc = 1'b0;
    arith_acc = 1'b0;
    if (inst_valid_i && inst_ready_i) begin
      case (inst_data_i.cfg.kind)
        KIND_CFG:   cfg_acc = 1'b1;
        KIND_ARITH: arith_acc = 1'b1;
      endcase
    end
  end

  // Requested length clamped to the lane count
  always_comb begin
    if (inst_data_i.cfg.avl > AVL_W'(NUM_LANES)) begin
      new_vl = VL_W'(NUM_LANES);
    end else begin
      new_vl = inst_data_i.cfg.avl[VL_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vl_q <= VL_W'(NUM_LANES);
      reg_write_valid_o <= 1'b0;
      cmd_valid_o <= 1'b0;
    end else begin
      if (cfg_acc) begin
        vl_q <= new_vl;
      end
      reg_write_valid_o <= cfg_acc;
      cmd_valid_o <= arith_acc;
    end
  end

  // Commands carry the length in force at decode
  always_ff @(posedge clk) begin
    if (cfg_acc) begin
      reg_write_addr_o <= inst_data_i.cfg.rd;
      reg_write_data_o <= ELEN'(new_vl);
    end
    if (arith_acc) begin
      cmd_o <= '{op:     inst_data_i.arith.funct,
                 vd:     inst_data_i.arith.vd,
                 vs1:    inst_data_i.arith.vs1,
                 vs2:    inst_data_i.arith.vs2,
                 rd:     inst_data_i.arith.rd,
                 scalar: scalar_i,
                 vl:     vl_q};
    end
  end

  assign config_vl_o = vl_q;
  assign busy_o = cmd_valid_o || reg_write_valid_o;

endmodule

`default_nettype wire

// File: rtl/rvv_core.sv
// Vector coprocessor top
`timescale 1ns/1ns
`default_nettype none

module rvv_core (
  input  logic                              clk,
  input  logic                              arst_n_i,
  // Instruction input
  input  logic                              inst_valid_i,
  input  rvv_isa_pkg::rvv_inst_u            inst_data_i,
  input  logic [rvv_cfg_pkg::ELEN-1:0]      scalar_i,
  output logic                              inst_ready_o,
  // Configuration writeback
  output logic                              reg_write_valid_o,
  output logic [rvv_cfg_pkg::XREG_AW-1:0]   reg_write_addr_o,
  output logic [rvv_cfg_pkg::ELEN-1:0]      reg_write_data_o,
  // Reduction writeback
  output logic                              async_rd_valid_o,
  output logic [rvv_cfg_pkg::XREG_AW-1:0]   async_rd_addr_o,
  output logic [rvv_cfg_pkg::ELEN-1:0]      async_rd_data_o,
  input  logic                              async_rd_ready_i,
  output logic [rvv_cfg_pkg::VL_W-1:0]      config_vl_o,
  output logic [rvv_cfg_pkg::CAP_W-1:0]     queue_capacity_o,
  output logic                              rvv_idle_o
);
  import rvv_cfg_pkg::*;
  import rvv_isa_pkg::*;

  logic                            fe_cmd_valid;
  rvv_cmd_t                        fe_cmd;
  logic                            fe_busy;
  logic [CQ_CNT_W-1:0]             q_free;
  logic                            q_empty;
  logic                            issue_valid;
  rvv_cmd_t                        issue_cmd;
  logic                            stall;
  rvv_lane_res_t [NUM_LANES-1:0]   lane_res;
  logic                            lane_busy;
  logic [ELEN-1:0]                 red_scalar_q;
  logic                            retire_busy;

  rvv_frontend i_frontend (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .inst_valid_i      (inst_valid_i),
    .inst_data_i       (inst_data_i),
    .scalar_i          (scalar_i),
    .inst_ready_i      (inst_ready_o),
    .reg_write_valid_o (reg_write_valid_o),
    .reg_write_addr_o  (reg_write_addr_o),
    .reg_write_data_o  (reg_write_data_o),
    .config_vl_o       (config_vl_o),
    .cmd_valid_o       (fe_cmd_valid),
    .cmd_o             (fe_cmd),
    .busy_o            (fe_busy)
  );

  // Back-pressure toward the scalar core
  always_comb begin
    if (q_free > CQ_CNT_W'(CAP_MAX)) begin
      queue_capacity_o = CAP_W'(CAP_MAX);
    end else begin
      queue_capacity_o = q_free[CAP_W-1:0];
    end
  end

  assign inst_ready_o = (queue_capacity_o != '0);

  rvv_cmd_queue i_cmd_queue (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .push_valid_i  (fe_cmd_valid),
    .push_cmd_i    (fe_cmd),
    .stall_i       (stall),
    .issue_valid_o (issue_valid),
    .issue_cmd_o   (issue_cmd),
    .free_o        (q_free),
    .empty_o       (q_empty)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    rvv_lane #(.LANE_IDX(g)) i_lane (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .issue_valid_i (issue_valid),
      .issue_cmd_i   (issue_cmd),
      .res_o         (lane_res[g])
    );
  end

  // Scalar operand follows its command into the lane result stage
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      red_scalar_q <= issue_cmd.scalar;
    end
  end

  rvv_retire i_retire (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .lane_res_i       (lane_res),
    .scalar_i         (red_scalar_q),
    .async_rd_ready_i (async_rd_ready_i),
    .async_rd_valid_o (async_rd_valid_o),
    .async_rd_addr_o  (async_rd_addr_o),
    .async_rd_data_o  (async_rd_data_o),
    .stall_o          (stall),
    .busy_o           (retire_busy)
  );

  always_comb begin
    lane_busy = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_busy = lane_busy || lane_res[i].valid;
    end
  end

  assign rvv_idle_o = !fe_busy && q_empty && !lane_busy && !retire_busy;

endmodule

`default_nettype wire
